// File: fpu_pkg.sv
// Shared types and constants for the single-cycle FP operation groups
package fpu_pkg;

  // ====================
  // Format widths
  // ====================
  localparam int flen  = 32;  // Single precision only
  localparam int exp_w = 8;   // Biased exponent
  localparam int man_w = 23;  // Stored fraction, hidden bit not kept

  typedef logic [flen-1:0] fp_word_t;

  // ====================
  // External operation codes
  // ====================
  // Same 5-bit values as the full FPU control path,
  // so the arithmetic codes stay free
  typedef enum logic [4:0] {
    op_sgnj  = 5'b00101,
    op_sgnjn = 5'b00110,
    op_sgnjx = 5'b00111,
    op_min   = 5'b01000,
    op_max   = 5'b01001,
    op_cmp   = 5'b01011,  // Sub-op from funct3
    op_class = 5'b01100,
    op_mv_xw = 5'b10001,  // FP bits to integer register
    op_mv_wx = 5'b10010   // Integer bits to FP register
  } fp_op_e;

  // Internal unit select after decode
  typedef enum logic [2:0] {
    unit_sign   = 3'd0,
    unit_minmax = 3'd1,
    unit_cmp    = 3'd2,
    unit_class  = 3'd3,
    unit_mv_x   = 3'd4,
    unit_mv_f   = 3'd5
  } unit_e;

  // Sub-operation, meaning depends on unit
  typedef logic [1:0] sub_op_t;

  localparam sub_op_t sub_j   = 2'd0;  // Sign: take b's sign
  localparam sub_op_t sub_n   = 2'd1;  // Sign: inverted b sign
  localparam sub_op_t sub_x   = 2'd2;  // Sign: XOR of signs
  localparam sub_op_t sub_min = 2'd0;
  localparam sub_op_t sub_max = 2'd1;
  localparam sub_op_t sub_eq  = 2'd0;
  localparam sub_op_t sub_lt  = 2'd1;
  localparam sub_op_t sub_le  = 2'd2;

  // Compare funct3 field values
  localparam logic [2:0] funct3_feq = 3'b010;
  localparam logic [2:0] funct3_flt = 3'b001;
  localparam logic [2:0] funct3_fle = 3'b000;

  // Canonical quiet NaN, positive sign
  localparam fp_word_t canon_nan = 32'h7fc0_0000;

  // ====================
  // Stage 1 payload
  // ====================
  typedef struct packed {
    unit_e       unit;
    sub_op_t     sub_op;
    fp_word_t    operand_a;
    fp_word_t    operand_b;
    logic [31:0] int_operand;  // Low word only, enough for FMV.W.X
  } dec_op_t;

endpackage

// File: fpu_pipe_stage.sv
`timescale 1ns/100ps

// One-entry valid/ready register, payload given as a type
module fpu_pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     valid_q;  // Entry occupied
  payload_t data_q;   // Held payload
  logic     load;

  // Free slot, or the current entry leaves this cycle
  assign in_ready = ~valid_q | out_ready;
  assign load     = in_valid & in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (in_ready) begin
      valid_q <= in_valid;  // Refill or drain
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= in_data;
    end
  end

  assign out_valid = valid_q;
  assign out_data  = data_q;

  // A stalled offer from upstream must keep valid and payload
  stall_hold_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    (in_valid && !in_ready) |=> (in_valid && $stable(in_data))
  ) else $error("Upstream dropped or changed a stalled entry");

endmodule

// File: fpu_op_decode.sv
`timescale 1ns/100ps

// Maps external op code and funct3 to unit select and sub-op
module fpu_op_decode (
  input  logic              clk,       // Assertion sampling only
  input  logic              rst_n,
  input  logic              in_valid,
  input  fpu_pkg::fp_op_e   op,
  input  logic [2:0]        funct3,
  input  fpu_pkg::fp_word_t operand_a,
  input  fpu_pkg::fp_word_t operand_b,
  input  logic [31:0]       int_operand,
  output fpu_pkg::dec_op_t  dec
);
  import fpu_pkg::*;

  unit_e   unit;
  sub_op_t sub_op;
  sub_op_t cmp_sub;

  // Compare flavour, unknown funct3 behaves as FEQ
  always_comb begin
    case (funct3)
      funct3_flt: cmp_sub = sub_lt;
      funct3_fle: cmp_sub = sub_le;
      default:    cmp_sub = sub_eq;
    endcase
  end

  // ====================
  // Unit select
  // ====================
  always_comb begin
    unit   = unit_sign;
    sub_op = sub_j;
    case (op)
      op_sgnj:  sub_op = sub_j;
      op_sgnjn: sub_op = sub_n;
      op_sgnjx: sub_op = sub_x;
      op_min: begin
        unit   = unit_minmax;
        sub_op = sub_min;
      end
      op_max: begin
        unit   = unit_minmax;
        sub_op = sub_max;
      end
      op_cmp: begin
        unit   = unit_cmp;
        sub_op = cmp_sub;
      end
      op_class: unit = unit_class;
      op_mv_xw: unit = unit_mv_x;
      op_mv_wx: unit = unit_mv_f;
      default: begin
        unit   = unit_sign;  // Illegal codes fall into plain FSGNJ
        sub_op = sub_j;
      end
    endcase
  end

  // Operands ride along unchanged
  assign dec.unit        = unit;
  assign dec.sub_op      = sub_op;
  assign dec.operand_a   = operand_a;
  assign dec.operand_b   = operand_b;
  assign dec.int_operand = int_operand;

  // Upstream must only issue the nine supported codes
  legal_op_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    in_valid |-> (op inside {op_sgnj, op_sgnjn, op_sgnjx, op_min, op_max,
                             op_cmp, op_class, op_mv_xw, op_mv_wx})
  ) else $error("Unsupported FP op code %b issued", op);

endmodule

// File: fpu_operand_class.sv
`timescale 1ns/100ps

// Field split and IEEE category flags for one single-precision operand
module fpu_operand_class (
  input  fpu_pkg::fp_word_t operand,
  output logic              sign,
  output logic              is_zero,
  output logic              is_sub,
  output logic              is_inf,
  output logic              is_nan,
  output logic              is_snan,
  output logic              is_qnan
);
  import fpu_pkg::*;

  logic [exp_w-1:0] exponent;
  logic [man_w-1:0] mantissa;
  logic             exp_ones;
  logic             exp_zero;
  logic             man_zero;

  assign sign     = operand[flen-1];
  assign exponent = operand[flen-2 -: exp_w];
  assign mantissa = operand[man_w-1:0];

  assign exp_ones = &exponent;   // Inf or NaN encoding
  assign exp_zero = ~|exponent;  // Zero or subnormal
  assign man_zero = ~|mantissa;

  assign is_zero = exp_zero & man_zero;
  assign is_sub  = exp_zero & ~man_zero;
  assign is_inf  = exp_ones & man_zero;
  assign is_nan  = exp_ones & ~man_zero;

  // Fraction MSB separates quiet from signalling
  assign is_qnan = is_nan & mantissa[man_w-1];
  assign is_snan = is_nan & ~mantissa[man_w-1];

endmodule

// File: fpu_execute.sv
`timescale 1ns/100ps

// Combinational datapath for the single-cycle FP groups
module fpu_execute #(
  parameter int xlen = 32
) (
  input  fpu_pkg::dec_op_t  dec,
  input  logic              a_sign,
  input  logic              a_is_zero,
  input  logic              a_is_sub,
  input  logic              a_is_inf,
  input  logic              a_is_nan,
  input  logic              a_is_snan,
  input  logic              a_is_qnan,
  input  logic              b_sign,
  input  logic              b_is_zero,
  input  logic              b_is_nan,
  input  logic              b_is_snan,
  output fpu_pkg::fp_word_t fp_result,
  output logic [xlen-1:0]   int_result,
  output logic              flag_nv,
  output logic              writes_int
);
  import fpu_pkg::*;

  fp_word_t   a;
  fp_word_t   b;
  logic       any_nan;
  logic       any_snan;
  logic       both_zero;
  logic       ord_lt;      // a below b in total order, -0 < +0
  logic       sign_inj;
  fp_word_t   sign_res;
  logic       pick_a;
  fp_word_t   minmax_res;
  logic       cmp_eq;
  logic       cmp_lt;
  logic       cmp_le;
  logic       cmp_bit;
  logic       cmp_nv;
  logic       a_normal;
  logic [9:0] class_mask;

  assign a = dec.operand_a;
  assign b = dec.operand_b;

  assign any_nan   = a_is_nan | b_is_nan;
  assign any_snan  = a_is_snan | b_is_snan;
  assign both_zero = a_is_zero & b_is_zero;

  // Sign-magnitude ordering, NaNs handled by the callers
  always_comb begin
    if (a_sign != b_sign) begin
      ord_lt = a_sign;                         // Negative side is lower
    end else if (a_sign) begin
      ord_lt = a[flen-2:0] > b[flen-2:0];      // Larger magnitude is lower
    end else begin
      ord_lt = a[flen-2:0] < b[flen-2:0];
    end
  end

  // ====================
  // Sign injection
  // ====================
  always_comb begin
    case (dec.sub_op)
      sub_n:   sign_inj = ~b_sign;
      sub_x:   sign_inj = a_sign ^ b_sign;
      default: sign_inj = b_sign;
    endcase
  end

  assign sign_res = {sign_inj, a[flen-2:0]};  // Magnitude always from a

  // ====================
  // Min / max
  // ====================
  assign pick_a = ord_lt ^ (dec.sub_op == sub_max);

  always_comb begin
    if (a_is_nan && b_is_nan) begin
      minmax_res = canon_nan;
    end else if (a_is_nan) begin
      minmax_res = b;       // Single NaN loses
    end else if (b_is_nan) begin
      minmax_res = a;
    end else begin
      minmax_res = pick_a ? a : b;
    end
  end

  // ====================
  // Compare
  // ====================
  assign cmp_eq = ~any_nan & (both_zero | (a == b));  // +0 equals -0
  assign cmp_lt = ~any_nan & ord_lt & ~both_zero;
  assign cmp_le = cmp_lt | cmp_eq;

  always_comb begin
    case (dec.sub_op)
      sub_lt: begin
        cmp_bit = cmp_lt;
        cmp_nv  = any_nan;   // Signalling compare
      end
      sub_le: begin
        cmp_bit = cmp_le;
        cmp_nv  = any_nan;
      end
      default: begin
        cmp_bit = cmp_eq;
        cmp_nv  = any_snan;  // Quiet compare
      end
    endcase
  end

  // Classify mask, one-hot
  assign a_normal = ~(a_is_zero | a_is_sub | a_is_inf | a_is_nan);

  assign class_mask = {a_is_qnan,
                       a_is_snan,
                       ~a_sign & a_is_inf,
                       ~a_sign & a_normal,
                       ~a_sign & a_is_sub,
                       ~a_sign & a_is_zero,
                       a_sign & a_is_zero,
                       a_sign & a_is_sub,
                       a_sign & a_normal,
                       a_sign & a_is_inf};  // Bit 0, -inf

  // Result select, unwritten side stays zero
  always_comb begin
    fp_result  = '0;
    int_result = '0;
    flag_nv    = 1'b0;
    writes_int = 1'b0;
    case (dec.unit)
      unit_sign: fp_result = sign_res;
      unit_minmax: begin
        fp_result = minmax_res;
        flag_nv   = any_snan;
      end
      unit_cmp: begin
        int_result = xlen'(cmp_bit);
        flag_nv    = cmp_nv;
        writes_int = 1'b1;
      end
      unit_class: begin
        int_result = xlen'(class_mask);
        writes_int = 1'b1;
      end
      unit_mv_x: begin
        int_result = xlen'($signed(a));  // Sign-extend on RV64
        writes_int = 1'b1;
      end
      unit_mv_f: fp_result = dec.int_operand;
      default: fp_result = '0;
    endcase
  end

endmodule

// File: fpu_misc_top.sv
`timescale 1ns/100ps

// Two-stage valid/ready pipeline around the single-cycle FP datapath
module fpu_misc_top #(
  parameter int xlen = 32  // 32 or 64
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  output logic              in_ready,
  input  fpu_pkg::fp_op_e   op,
  input  logic [2:0]        funct3,
  input  fpu_pkg::fp_word_t operand_a,
  input  fpu_pkg::fp_word_t operand_b,
  input  logic [xlen-1:0]   int_operand,
  output logic              out_valid,
  input  logic              out_ready,
  output fpu_pkg::fp_word_t fp_result,
  output logic [xlen-1:0]   int_result,
  output logic              flag_nv,
  output logic              writes_int
);
  import fpu_pkg::*;

  // Stage 2 payload, width follows xlen
  typedef struct packed {
    fp_word_t        fp_result;
    logic [xlen-1:0] int_result;
    logic            flag_nv;
    logic            writes_int;
  } res_t;

  dec_op_t dec_d;     // Decode output
  dec_op_t dec_q;     // Stage 1 register
  logic    s1_valid;
  logic    s2_ready;
  res_t    res_d;     // Execute output
  res_t    res_q;     // Stage 2 register
  logic    a_sign, a_is_zero, a_is_sub, a_is_inf;
  logic    a_is_nan, a_is_snan, a_is_qnan;
  logic    b_sign, b_is_zero, b_is_nan, b_is_snan;

  // ====================
  // Decode and stage 1
  // ====================
  fpu_op_decode fpu_op_decode_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .op          (op),
    .funct3      (funct3),
    .operand_a   (operand_a),
    .operand_b   (operand_b),
    .int_operand (int_operand[31:0]),
    .dec         (dec_d)
  );

  fpu_pipe_stage #(.payload_t(dec_op_t)) stage1_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (dec_d),
    .out_valid (s1_valid),
    .out_ready (s2_ready),
    .out_data  (dec_q)
  );

  fpu_operand_class class_a_i (
    .operand (dec_q.operand_a),
    .sign    (a_sign),
    .is_zero (a_is_zero),
    .is_sub  (a_is_sub),
    .is_inf  (a_is_inf),
    .is_nan  (a_is_nan),
    .is_snan (a_is_snan),
    .is_qnan (a_is_qnan)
  );

  // Only the flags used by min/max and compare
  fpu_operand_class class_b_i (
    .operand (dec_q.operand_b),
    .sign    (b_sign),
    .is_zero (b_is_zero),
    .is_sub  (),
    .is_inf  (),
    .is_nan  (b_is_nan),
    .is_snan (b_is_snan),
    .is_qnan ()
  );

  // ====================
  // Execute and stage 2
  // ====================
  fpu_execute #(.xlen(xlen)) fpu_execute_i (
    .dec        (dec_q),
    .a_sign     (a_sign),
    .a_is_zero  (a_is_zero),
    .a_is_sub   (a_is_sub),
    .a_is_inf   (a_is_inf),
    .a_is_nan   (a_is_nan),
    .a_is_snan  (a_is_snan),
    .a_is_qnan  (a_is_qnan),
    .b_sign     (b_sign),
    .b_is_zero  (b_is_zero),
    .b_is_nan   (b_is_nan),
    .b_is_snan  (b_is_snan),
    .fp_result  (res_d.fp_result),
    .int_result (res_d.int_result),
    .flag_nv    (res_d.flag_nv),
    .writes_int (res_d.writes_int)
  );

  fpu_pipe_stage #(.payload_t(res_t)) stage2_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (s1_valid),
    .in_ready  (s2_ready),
    .in_data   (res_d),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (res_q)
  );

  assign fp_result  = res_q.fp_result;   // Unpack to loose ports
  assign int_result = res_q.int_result;
  assign flag_nv    = res_q.flag_nv;
  assign writes_int = res_q.writes_int;

endmodule

// File: tb_fpu_tasks.svh
// Compare an observed value with its expected value
task automatic check_value(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
  if (got !== exp) begin
    fail_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
  end
endtask

function automatic logic [31:0] rnd32();
  return $random(seed);
endfunction

// ====================
// Reference model
// ====================
// Unsigned key along the number line, -0 just under +0
function automatic logic [31:0] order_key(input logic [31:0] v);
  return v[31] ? ~v : {1'b1, v[30:0]};
endfunction

function automatic logic nan_of(input logic [31:0] v);
  return (v[30:23] == 8'hff) && (v[22:0] != 23'd0);
endfunction

function automatic logic snan_of(input logic [31:0] v);
  return nan_of(v) && !v[22];  // Quiet bit clear
endfunction

function automatic logic [63:0] class_of(input logic [31:0] v);
  int idx;
  if (nan_of(v)) idx = v[22] ? 9 : 8;
  else if (v[30:23] == 8'hff) idx = v[31] ? 0 : 7;  // Infinities
  else if (v[30:0] == 31'd0) idx = v[31] ? 3 : 4;   // Zeros
  else if (v[30:23] == 8'h00) idx = v[31] ? 2 : 5;  // Subnormals
  else idx = v[31] ? 1 : 6;
  return 64'd1 << idx;
endfunction

// Expected outputs for one operation, pushed in issue order
task automatic predict(input fp_op_e o, input logic [2:0] f3, input logic [31:0] a,
                       input logic [31:0] b, input logic [63:0] x);
  logic [31:0] fp;
  logic [63:0] iv;
  logic        nv;
  logic        wi;
  logic        any_nan;
  logic        eq;
  logic        lt;
  fp      = '0;
  iv      = '0;
  nv      = 1'b0;
  wi      = 1'b0;
  any_nan = nan_of(a) || nan_of(b);
  eq      = !any_nan && (a == b || (a[30:0] == 31'd0 && b[30:0] == 31'd0));
  lt      = !any_nan && !eq && (order_key(a) < order_key(b));
  case (o)
    op_sgnj:  fp = {b[31], a[30:0]};
    op_sgnjn: fp = {~b[31], a[30:0]};
    op_sgnjx: fp = {a[31] ^ b[31], a[30:0]};
    op_min, op_max: begin
      nv = snan_of(a) || snan_of(b);
      if (nan_of(a) && nan_of(b)) fp = canon_nan;
      else if (nan_of(a)) fp = b;  // NaN loses to a number
      else if (nan_of(b)) fp = a;
      else fp = ((order_key(a) < order_key(b)) == (o == op_min)) ? a : b;
    end
    op_cmp: begin
      wi = 1'b1;
      case (f3)
        funct3_flt: iv = 64'(lt);
        funct3_fle: iv = 64'(lt || eq);
        default:    iv = 64'(eq);  // Unused codes act as FEQ
      endcase
      // Signalling compares flag any NaN
      nv = (f3 == funct3_flt || f3 == funct3_fle) ? any_nan : (snan_of(a) || snan_of(b));
    end
    op_class: begin
      iv = class_of(a);
      wi = 1'b1;
    end
    op_mv_xw: begin
      iv = {{32{a[31]}}, a} & ((64'd1 << xlen) - 64'd1);  // Sign-extend to xlen
      wi = 1'b1;
    end
    op_mv_wx: fp = x[31:0];
    default:  fail_run("Reference model got an unsupported op code");
  endcase
  exp_fp.push_back(fp);
  exp_int.push_back(iv);
  exp_nv.push_back(nv);
  exp_wi.push_back(wi);
endtask

// ====================
// Driver
// ====================
// Called 2 ns after an edge, returns 2 ns after the accepting edge
task automatic issue_op(input fp_op_e o, input logic [2:0] f3, input logic [31:0] a,
                        input logic [31:0] b, input logic [63:0] x);
  in_valid    = 1'b1;
  op          = o;
  funct3      = f3;
  operand_a   = a;
  operand_b   = b;
  int_operand = x[xlen-1:0];
  @(negedge clk);
  if (lat_check) check_value("in_ready", 64'(in_ready), 64'd1);  // No stall expected
  while (!in_ready) @(negedge clk);
  predict(o, f3, a, b, x);
  exp_cyc.push_back(cycle);
  issued++;
  @(posedge clk);  // Transfer edge
  #2;
  in_valid = 1'b0;
endtask

task automatic wait_drain();
  while (exp_fp.size() != 0) @(negedge clk);
  @(posedge clk);
  #2;
endtask

// ====================
// Directed tests
// ====================
task automatic sign_inj_test();
  logic [31:0] pairs[$] = '{32'h3f80_0000, 32'hbf80_0000, 32'hc049_0fdb, 32'h4000_0000,
                            32'h7fc0_0000, 32'hff80_0000, 32'h8000_0000, 32'h0000_0000};
  logic [31:0] a;
  logic [31:0] b;
  for (int i = 0; i < 12; i++) begin
    if (i < 4) begin
      a = pairs[2*i];
      b = pairs[2*i+1];
    end else begin
      a = rnd32();
      b = rnd32();
    end
    issue_op(op_sgnj, 3'b000, a, b, '0);
    issue_op(op_sgnjn, 3'b000, a, b, '0);
    issue_op(op_sgnjx, 3'b000, a, b, '0);
  end
  wait_drain();
endtask

task automatic minmax_test();
  logic [31:0] pairs[$] = '{32'h0000_0000, 32'h8000_0000, 32'h8000_0000, 32'h0000_0000,
                            32'h7fc0_0000, 32'h3f80_0000, 32'hc000_0000, 32'h7fc1_2345,
                            32'h7fd0_0000, 32'hffc0_0001, 32'h7f80_0001, 32'h3f80_0000,
                            32'h3f80_0000, 32'hff80_0001};
  logic [31:0] a;
  logic [31:0] b;
  for (int i = 0; i < 15; i++) begin
    if (i < 7) begin
      a = pairs[2*i];
      b = pairs[2*i+1];
    end else begin
      a = rnd32();
      b = rnd32();
    end
    issue_op(op_min, 3'b000, a, b, '0);
    issue_op(op_max, 3'b000, a, b, '0);
  end
  wait_drain();
endtask

task automatic compare_test();
  logic [31:0] pairs[$] = '{32'h3f80_0000, 32'h3f80_0000, 32'h3f80_0000, 32'h4000_0000,
                            32'h4000_0000, 32'h3f80_0000, 32'h8000_0000, 32'h0000_0000,
                            32'h7fc0_0000, 32'h3f80_0000, 32'h7f80_0001, 32'h3f80_0000,
                            32'hbf80_0000, 32'h3f80_0000};
  logic [2:0]  codes[$] = '{funct3_feq, funct3_flt, funct3_fle, 3'b111};
  foreach (codes[c]) begin
    for (int i = 0; i < 7; i++) begin
      issue_op(op_cmp, codes[c], pairs[2*i], pairs[2*i+1], '0);
    end
  end
  wait_drain();
endtask

// One operand per class, listed in mask bit order
task automatic class_test();
  logic [31:0] vals[$] = '{32'hff80_0000, 32'hbf80_0000, 32'h807f_ffff, 32'h8000_0000,
                           32'h0000_0000, 32'h0000_0001, 32'h3f80_0000, 32'h7f80_0000,
                           32'h7f80_0001, 32'h7fc0_0000};
  foreach (vals[i]) begin
    check_value("class_mask", class_of(vals[i]), 64'd1 << i);  // Model sanity
    issue_op(op_class, 3'b000, vals[i], '0, '0);
  end
  wait_drain();
endtask

task automatic move_test();
  logic [31:0] hi;
  logic [31:0] lo;
  issue_op(op_mv_xw, 3'b000, 32'hbf80_0000, rnd32(), '0);  // Bit 31 set
  issue_op(op_mv_xw, 3'b000, 32'h4049_0fdb, rnd32(), '0);
  hi = rnd32();
  lo = rnd32();
  issue_op(op_mv_wx, 3'b000, rnd32(), rnd32(), {hi, lo});
  wait_drain();
endtask

// Random op mix under random out_ready
task automatic stream_test();
  fp_op_e      ops[$] = '{op_sgnj, op_sgnjn, op_sgnjx, op_min, op_max, op_cmp,
                          op_class, op_mv_xw, op_mv_wx};
  logic [31:0] r;
  logic [31:0] hi;
  lat_check    = 1'b0;
  toggle_ready = 1'b1;
  for (int i = 0; i < 300; i++) begin
    r  = rnd32();
    hi = rnd32();
    issue_op(ops[r % 9], r[14:12], rnd32(), rnd32(), {hi, rnd32()});
  end
  toggle_ready = 1'b0;
  out_ready    = 1'b1;
  wait_drain();
  lat_check = 1'b1;
endtask

// File: tb_fpu_misc.sv
`timescale 1ns/100ps

module tb_fpu_misc;
  import fpu_pkg::*;

  localparam int xlen   = 32;
  localparam int period = 40;  // ns

  logic            clk = 1'b0;
  logic            rst_n;
  logic            in_valid;
  logic            in_ready;
  fp_op_e          op;
  logic [2:0]      funct3;
  fp_word_t        operand_a;
  fp_word_t        operand_b;
  logic [xlen-1:0] int_operand;
  logic            out_valid;
  logic            out_ready;
  fp_word_t        fp_result;
  logic [xlen-1:0] int_result;
  logic            flag_nv;
  logic            writes_int;

  // ====================
  // Scoreboard state
  // ====================
  logic [31:0] exp_fp[$];   // Expected results, issue order
  logic [63:0] exp_int[$];
  logic        exp_nv[$];
  logic        exp_wi[$];
  int          exp_cyc[$];  // Cycle of each input transfer

  integer seed;
  integer ready_seed;                // Own stream for out_ready toggling
  int     cycle        = 0;
  int     issued       = 0;
  int     received     = 0;
  logic   lat_check    = 1'b1;       // Latency only meaningful with out_ready high
  logic   toggle_ready = 1'b0;

  fpu_misc_top #(.xlen(xlen)) fpu_misc_top_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .op          (op),
    .funct3      (funct3),
    .operand_a   (operand_a),
    .operand_b   (operand_b),
    .int_operand (int_operand),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .fp_result   (fp_result),
    .int_result  (int_result),
    .flag_nv     (flag_nv),
    .writes_int  (writes_int)
  );

  initial begin
    forever begin
      #(period/2) clk = ~clk;
    end
  end

  always @(posedge clk) cycle <= cycle + 1;  // Free-running cycle count

  // Prints the reason, then ends the run as failed
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  `include "tb_fpu_tasks.svh"

  // Cycle budget grows with the number of issued operations
  initial begin
    forever begin
      @(negedge clk);
      if (cycle > 20 * (issued + 50)) begin
        fail_run("Timeout: results stopped arriving within the cycle budget");
      end
    end
  end

  // Output monitor, mid-cycle where every handshake signal is settled
  initial begin
    int acc_cycle;
    forever begin
      @(negedge clk);
      if (rst_n && out_valid && out_ready) begin
        if (exp_fp.size() == 0) begin
          fail_run("Output transfer with no operation outstanding");
        end
        acc_cycle = exp_cyc.pop_front();
        check_value("fp_result", 64'(fp_result), 64'(exp_fp.pop_front()));
        check_value("int_result", 64'(int_result), exp_int.pop_front());
        check_value("flag_nv", 64'(flag_nv), 64'(exp_nv.pop_front()));
        check_value("writes_int", 64'(writes_int), 64'(exp_wi.pop_front()));
        if (lat_check) begin
          check_value("latency", 64'(cycle - acc_cycle), 64'd2);  // Two stages
        end
        received++;
      end
    end
  end

  // Random back-pressure, same drive offset as the stimulus
  initial begin
    integer r;
    forever begin
      @(posedge clk);
      #2;
      if (toggle_ready) begin
        r         = $random(ready_seed);
        out_ready = r[0];
      end
    end
  end

  // ====================
  // Test sequence
  // ====================
  initial begin
    seed        = 32'h4a5d_5ca1;
    ready_seed  = seed + 1;
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    op          = op_sgnj;
    funct3      = 3'b000;
    operand_a   = '0;
    operand_b   = '0;
    int_operand = '0;
    out_ready   = 1'b1;
    repeat (10) @(posedge clk);  // Reset held 10 cycles
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("out_valid", 64'(out_valid), 64'd0);  // Both stages empty
    check_value("in_ready", 64'(in_ready), 64'd1);
    @(posedge clk);
    #2;
    sign_inj_test();
    minmax_test();
    compare_test();
    class_test();
    move_test();
    stream_test();
    if (received == issued && exp_fp.size() == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      fail_run("Number of results differs from number of issued operations");
    end
  end

endmodule

// File: fpu_misc.f
+incdir+.
fpu_pkg.sv
fpu_pipe_stage.sv
fpu_op_decode.sv
fpu_operand_class.sv
fpu_execute.sv
fpu_misc_top.sv
tb_fpu_misc.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert --top-module tb_fpu_misc \
  -f fpu_misc.f -o sim_fpu_misc > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_fpu_misc > sim.log 2>&1
cat sim.log
grep -qx "Regression passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
